// ==== sources.f ====
+incdir+design
design/parking_pkg.sv
design/order_queue.sv
design/spot_allocator.sv
design/slot_table.sv
design/lift_controller.sv
design/parking_lot_top.sv
test/parking_lot_chk.sv
test/parking_lot_tb.sv

// ==== Makefile ====
# Verilator build and run for the parking tower testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = parking_lot_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_TEXT = Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/parking_lot_tb.sv ====
// Parking tower testbench
// Random park and retrieve orders checked against a reference model of the tower
`include "parking_defines.svh"

module parking_lot_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import parking_pkg::*;

	localparam int DRAIN_LIMIT = 1000; // Cycles the lift gets to empty its queue

	logic       clock;
	logic       reset;
	logic       in_mode;
	logic       out_mode;
	plate_t     license_plate;
	lot_event_t lot_event;
	floor_t     current_floor;
	logic       queue_full;
	logic [3:0] free_suv_count;
	logic [3:0] free_sedan_count;

	order_t model_q [$];     // Accepted orders not yet finished
	plate_t occ [16];        // Model occupancy by spot number, 0 and 1 unused
	int     park_cycle [16];
	plate_t sent_plates [$];
	logic   deliver_pending; // Picked car still on its way down
	plate_t deliver_plate;
	spot_t  deliver_spot;
	logic   serving;         // Head of model_q is with the lift
	int     idle_cycle;      // First cycle the lift is idle at floor 0 again
	logic   timed_out;
	int     cycles;
	int     dropped;
	int     value_errors;
	int     other_errors;

	parking_lot_top parking_lot_top_inst (
		.clock            (clock),
		.reset            (reset),
		.in_mode          (in_mode),
		.out_mode         (out_mode),
		.license_plate    (license_plate),
		.lot_event        (lot_event),
		.current_floor    (current_floor),
		.queue_full       (queue_full),
		.free_suv_count   (free_suv_count),
		.free_sedan_count (free_sedan_count)
	);

	always #50 clock = ~clock;

	always @(posedge clock) cycles++;

	task automatic check_event(input string name, input lot_event_t got, input lot_event_t want);
		if (got.kind !== want.kind || got.plate !== want.plate || got.spot !== want.spot) begin
			value_errors++;
			$display("CHECK FAILED %s: got %h/%h/%h, expected %h/%h/%h (kind/plate/spot)",
				name, got.kind, got.plate, got.spot, want.kind, want.plate, want.spot);
		end
	endtask

	task automatic check_fee(input string name, input fee_t got, input fee_t want);
		if (got !== want) begin
			value_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_count(input string name, input logic [3:0] got, input logic [3:0] want);
		if (got !== want) begin
			value_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			value_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	function automatic plate_t random_plate();
		logic [3:0] cls;
		cls = ($urandom_range(0, 2) == 0) ? 4'($urandom_range(8, 9)) : 4'($urandom_range(0, 15));
		return {cls, 12'($urandom)};
	endfunction

	function automatic plate_t retrieve_plate();
		if (sent_plates.size() == 0 || $urandom_range(0, 4) == 0)
			return random_plate(); // Most likely unknown to the tower
		return sent_plates[$urandom_range(0, sent_plates.size() - 1)];
	endfunction

	function automatic spot_t find_plate(input plate_t p);
		for (int s = 2; s < 16; s++)
			if (p != '0 && occ[s] == p)
				return spot_t'(s);
		return '0;
	endfunction

	// Own floor type first, sedans then fall back to odd floors
	function automatic spot_t pick_spot(input plate_t p);
		logic hc;
		hc = (p[15:12] == 4'(`CLASS_HANDICAP));
		for (int pass = 0; pass < 2; pass++)
			for (int fl = 1; fl <= `FLOOR_COUNT; fl++)
				for (int side = 0; side < 2; side++)
					if (((fl % 2 == 1) == (p[0] || pass == 1)) && occ[fl * 2 + side] == '0 &&
						(hc || side == 1 || fl > 2))
						return spot_t'(fl * 2 + side);
		return '0;
	endfunction

	function automatic fee_t expected_fee(input plate_t p, input int edges);
		int rate;
		int total;
		if (p[15:12] == 4'(`CLASS_HANDICAP))
			rate = 0;
		else if (p[15:12] == 4'(`CLASS_HYBRID))
			rate = `RATE_HYBRID;
		else
			rate = `RATE_NORMAL;
		total = rate * (edges - 1); // Storing edge clears the meter
		return (total > `FEE_MAX) ? fee_t'(`FEE_MAX) : fee_t'(total);
	endfunction

	task automatic handle_event(input lot_event_t got);
		lot_event_t want;
		order_t     o;
		spot_t      s;
		fee_t       fee;
		fee       = '0;
		want      = '0;
		want.kind = EV_REJECTED;
		if (deliver_pending) begin
			want.kind       = EV_DELIVERED;
			want.plate      = deliver_plate;
			want.spot       = deliver_spot;
			deliver_pending = 1'b0;
		end else if (!serving) begin
			other_errors++;
			$display("Lot event %0d seen while the lift should be idle", got.kind);
			return;
		end else begin
			o          = model_q.pop_front();
			serving    = 1'b0;
			want.plate = o.plate;
			if (o.kind == ORDER_PARK) begin
				s = pick_spot(o.plate);
				if (o.plate != '0 && find_plate(o.plate) == '0 && s != '0) begin
					want.kind     = EV_PARKED;
					want.spot     = s;
					occ[s]        = o.plate;
					park_cycle[s] = cycles;
				end
			end else begin
				s = find_plate(o.plate);
				if (s != '0) begin
					want.kind       = EV_PICKED;
					want.spot       = s;
					fee             = expected_fee(o.plate, cycles - park_cycle[s]);
					occ[s]          = '0;
					deliver_pending = 1'b1;
					deliver_plate   = o.plate;
					deliver_spot    = s;
				end
			end
			// Back down from the spot floor, a rejection frees the lift next cycle
			idle_cycle = cycles + int'(floor_t'(want.spot >> 1)) + 1;
		end
		check_event("lot_event", got, want);
		check_fee("lot_event.fee", got.fee, fee);
	endtask

	// Queue and lift pop timing mirrored once per cycle
	task automatic model_step();
		order_t o;
		int     queued;
		if (lot_event.kind != EV_NONE)
			handle_event(lot_event);
		queued = model_q.size() - int'(serving);
		check_flag("queue_full", queue_full, queued == `QUEUE_DEPTH);
		if (in_mode || out_mode) begin
			o.kind  = in_mode ? ORDER_PARK : ORDER_RETRIEVE; // Park wins a tie
			o.plate = license_plate;
			if (queued == `QUEUE_DEPTH) begin
				dropped++;
			end else begin
				model_q.push_back(o);
				if (o.kind == ORDER_PARK && o.plate != '0)
					sent_plates.push_back(o.plate);
			end
		end
		if (!serving && queued != 0 && cycles >= idle_cycle)
			serving = 1'b1;
	endtask

	always @(negedge clock) begin
		#1;
		if (!reset)
			model_step();
	end

	task automatic send_order(input order_kind_e kind, input plate_t plate, input logic tie);
		@(negedge clock);
		in_mode       = (kind == ORDER_PARK);
		out_mode      = (kind == ORDER_RETRIEVE) || tie; // A tie still parks
		license_plate = plate;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clock);
			in_mode  = 1'b0;
			out_mode = 1'b0;
		end
	endtask

	function automatic logic lift_busy();
		return model_q.size() != 0 || deliver_pending || current_floor != '0;
	endfunction

	task automatic finish_run();
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	task automatic drain_orders();
		int         waited;
		logic [3:0] want_suv;
		logic [3:0] want_sedan;
		waited     = 0;
		want_suv   = '0;
		want_sedan = '0;
		idle_cycles(1);
		@(posedge clock);
		#25; // Mid-cycle, clear of edges and model updates
		while (lift_busy() && waited < DRAIN_LIMIT) begin
			@(posedge clock);
			#25;
			waited++;
		end
		if (lift_busy()) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout: lift still busy after %0d cycles", DRAIN_LIMIT);
		end else begin
			for (int fl = 1; fl <= `FLOOR_COUNT; fl++)
				for (int side = 0; side < 2; side++)
					if (occ[fl * 2 + side] == '0 && !(side == 0 && fl <= 2)) begin
						if (fl % 2 == 1)
							want_suv++;
						else
							want_sedan++;
					end
			check_count("free_suv_count", free_suv_count, want_suv);
			check_count("free_sedan_count", free_sedan_count, want_sedan);
		end
	endtask

	task automatic run_sequence();
		// Fill one order at a time, past full so late parks are turned away
		for (int i = 0; i < 18; i++) begin
			send_order(ORDER_PARK, random_plate(), 1'b0);
			drain_orders();
			if (timed_out)
				return;
		end
		send_order(ORDER_PARK, '0, 1'b0);
		send_order(ORDER_PARK, sent_plates[0], 1'b0); // Duplicate
		drain_orders();
		if (timed_out)
			return;

		for (int i = 0; i < 40; i++) begin
			if ($urandom_range(0, 1) == 0)
				send_order(ORDER_PARK, random_plate(), $urandom_range(0, 7) == 0);
			else
				send_order(ORDER_RETRIEVE, retrieve_plate(), 1'b0);
			idle_cycles($urandom_range(1, 12));
		end
		drain_orders();
		if (timed_out)
			return;

		// Back-to-back burst overflows the queue
		for (int i = 0; i < 20; i++)
			send_order($urandom_range(0, 1) ? ORDER_PARK : ORDER_RETRIEVE, retrieve_plate(), 1'b0);
		drain_orders();
		if (timed_out)
			return;
		if (dropped == 0) begin
			other_errors++;
			$display("The order queue never filled during the burst");
		end

		// Long stay, then empty the tower so the meters saturate
		idle_cycles(300);
		for (int s = 2; s < 16; s++) begin
			if (occ[s] != '0) begin
				send_order(ORDER_RETRIEVE, occ[s], 1'b0);
				drain_orders();
				if (timed_out)
					return;
			end
		end
	endtask

	initial begin
		void'($urandom(32'hc495b7c3));
		clock           = 1'b0;
		reset           = 1'b1;
		in_mode         = 1'b0;
		out_mode        = 1'b0;
		license_plate   = '0;
		deliver_pending = 1'b0;
		serving         = 1'b0;
		idle_cycle      = 0;
		timed_out       = 1'b0;
		cycles          = 0;
		dropped         = 0;
		value_errors    = 0;
		other_errors    = 0;
		foreach (occ[s])
			occ[s] = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		run_sequence();
		finish_run();
	end

endmodule

// ==== test/parking_lot_chk.sv ====
// Lift checker
// Assertions on lift movement and lot events, bound into the lift controller
`include "parking_defines.svh"

module parking_lot_chk (
	input logic                    clock,
	input logic                    reset,
	input parking_pkg::floor_t     current_floor,
	input parking_pkg::lot_event_t lot_event
);
	timeunit 1ns;
	timeprecision 100ps;
	import parking_pkg::*;

	assert property (@(posedge clock) reset |-> lot_event.kind == EV_NONE)
		else $error("lot event raised while reset is held");

	assert property (@(posedge clock) disable iff (reset)
		current_floor <= floor_t'(`FLOOR_COUNT))
		else $error("lift is above the top floor");

	// One floor per cycle at most, up or down
	assert property (@(posedge clock) disable iff (reset)
		(int'(current_floor) - int'($past(current_floor))) inside {-1, 0, 1})
		else $error("lift moved more than one floor in a cycle");

	assert property (@(posedge clock) disable iff (reset)
		(lot_event.kind inside {EV_PARKED, EV_PICKED}) |-> current_floor == lot_event.spot[3:1])
		else $error("spot served away from its floor");

endmodule

bind lift_controller parking_lot_chk lift_chk_inst (
	.clock         (clock),
	.reset         (reset),
	.current_floor (current_floor),
	.lot_event     (lot_event)
);

// ==== design/parking_lot_top.sv ====
// Parking tower top level
// Order queue, spot allocator, slot table and lift controller
module parking_lot_top (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    in_mode,
	input  logic                    out_mode,
	input  parking_pkg::plate_t     license_plate,
	output parking_pkg::lot_event_t lot_event,
	output parking_pkg::floor_t     current_floor,
	output logic                    queue_full,
	output logic [3:0]              free_suv_count,
	output logic [3:0]              free_sedan_count
);
	import parking_pkg::*;

	order_t     head_order;
	logic       queue_empty;
	logic       pop;
	plate_t     decide_plate;
	occupancy_t occupancy;
	spot_t      free_spot;
	spot_t      found_spot;
	logic       free_found;
	logic       plate_found;
	fee_t       picked_fee;
	logic       slot_write;
	logic       slot_clear;
	spot_t      slot_spot;
	plate_t     slot_plate;

	order_queue order_queue_inst (
		.clock         (clock),
		.reset         (reset),
		.in_mode       (in_mode),
		.out_mode      (out_mode),
		.license_plate (license_plate),
		.pop           (pop),
		.head_order    (head_order),
		.queue_empty   (queue_empty),
		.queue_full    (queue_full)
	);

	spot_allocator spot_allocator_inst (
		.plate       (decide_plate),
		.occupancy   (occupancy),
		.free_spot   (free_spot),
		.found_spot  (found_spot),
		.free_found  (free_found),
		.plate_found (plate_found)
	);

	slot_table slot_table_inst (
		.clock            (clock),
		.reset            (reset),
		.slot_write       (slot_write),
		.slot_clear       (slot_clear),
		.slot_spot        (slot_spot),
		.slot_plate       (slot_plate),
		.occupancy        (occupancy),
		.picked_fee       (picked_fee),
		.free_suv_count   (free_suv_count),
		.free_sedan_count (free_sedan_count)
	);

	lift_controller lift_controller_inst (
		.clock         (clock),
		.reset         (reset),
		.head_order    (head_order),
		.queue_empty   (queue_empty),
		.pop           (pop),
		.free_spot     (free_spot),
		.found_spot    (found_spot),
		.free_found    (free_found),
		.plate_found   (plate_found),
		.picked_fee    (picked_fee),
		.decide_plate  (decide_plate),
		.slot_write    (slot_write),
		.slot_clear    (slot_clear),
		.slot_spot     (slot_spot),
		.slot_plate    (slot_plate),
		.current_floor (current_floor),
		.lot_event     (lot_event)
	);

endmodule

// ==== design/lift_controller.sv ====
// Lift controller
// Serves one queued order at a time, drives the slot table and reports lot events
module lift_controller (
	input  logic                    clock,
	input  logic                    reset,
	input  parking_pkg::order_t     head_order,
	input  logic                    queue_empty,
	output logic                    pop,
	input  parking_pkg::spot_t      free_spot,
	input  parking_pkg::spot_t      found_spot,
	input  logic                    free_found,
	input  logic                    plate_found,
	input  parking_pkg::fee_t       picked_fee,
	output parking_pkg::plate_t     decide_plate,
	output logic                    slot_write,
	output logic                    slot_clear,
	output parking_pkg::spot_t      slot_spot,
	output parking_pkg::plate_t     slot_plate,
	output parking_pkg::floor_t     current_floor,
	output parking_pkg::lot_event_t lot_event
);
	import parking_pkg::*;

	lift_state_e state;
	lift_state_e next_state;
	floor_t      next_floor;
	order_t      order_q;    // Order being served
	spot_t       target_q;
	spot_t       decide_spot;
	logic        park_order;
	logic        reject;
	logic        at_target;

	assign park_order   = (order_q.kind == ORDER_PARK);
	assign decide_plate = order_q.plate;
	assign decide_spot  = park_order ? free_spot : found_spot;

	// Zero plate, duplicate park, unknown retrieve or a full tower
	assign reject = (order_q.plate == '0) ||
		(park_order ? (plate_found || !free_found) : !plate_found);

	assign at_target = (current_floor == floor_t'(target_q >> 1));

	assign pop = (state == LIFT_IDLE) && (current_floor == '0) && !queue_empty;

	assign slot_spot  = target_q;
	assign slot_plate = order_q.plate;
	assign slot_write = (state == LIFT_ASCEND) && at_target && park_order;
	assign slot_clear = (state == LIFT_ASCEND) && at_target && !park_order;

	always_comb begin
		next_state      = state;
		next_floor      = current_floor;
		lot_event.kind  = EV_NONE;
		lot_event.plate = order_q.plate;
		lot_event.spot  = target_q;
		lot_event.fee   = '0;
		case (state)
			LIFT_IDLE: begin
				if (pop)
					next_state = LIFT_DECIDE;
			end
			LIFT_DECIDE: begin
				if (reject) begin
					next_state     = LIFT_IDLE;
					lot_event.kind = EV_REJECTED;
					lot_event.spot = '0;
				end else begin
					next_state = LIFT_ASCEND;
				end
			end
			LIFT_ASCEND: begin
				if (at_target) begin
					// Start down in the same step that serves the spot
					next_state = LIFT_DESCEND;
					next_floor = current_floor - 1'b1;
					lot_event.kind = park_order ? EV_PARKED : EV_PICKED;
					if (!park_order)
						lot_event.fee = picked_fee;
				end else begin
					next_floor = current_floor + 1'b1;
				end
			end
			LIFT_DESCEND: begin
				if (current_floor == '0) begin
					next_state = LIFT_IDLE;
					if (!park_order)
						lot_event.kind = EV_DELIVERED; // Car handed out at ground floor
				end else begin
					next_floor = current_floor - 1'b1;
				end
			end
			default: next_state = LIFT_IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state         <= LIFT_IDLE;
			current_floor <= '0;
		end else begin
			state         <= next_state;
			current_floor <= next_floor;
		end
	end

	always_ff @(posedge clock) begin
		if (pop)
			order_q <= head_order;
		if (state == LIFT_DECIDE)
			target_q <= decide_spot;
	end

endmodule

// ==== design/slot_table.sv ====
// Slot table
// Parked plates, per-spot saturating fee meters and free-spot counts
`include "parking_defines.svh"

module slot_table (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    slot_write,
	input  logic                    slot_clear,
	input  parking_pkg::spot_t      slot_spot,
	input  parking_pkg::plate_t     slot_plate,
	output parking_pkg::occupancy_t occupancy,
	output parking_pkg::fee_t       picked_fee,
	output logic [3:0]              free_suv_count,
	output logic [3:0]              free_sedan_count
);
	import parking_pkg::*;

	localparam int SPOTS = 2 * `FLOOR_COUNT;

	fee_t  fee [SPOTS];
	spot_t slot_idx;
	logic  slot_valid; // Floor 0 holds no spots

	function automatic fee_t class_rate(input plate_t p);
		case (p[`PLATE_W-1 -: 4])
			4'(`CLASS_HANDICAP): return '0;
			4'(`CLASS_HYBRID):   return fee_t'(`RATE_HYBRID);
			default:             return fee_t'(`RATE_NORMAL);
		endcase
	endfunction

	function automatic fee_t add_sat(input fee_t a, input fee_t b);
		logic [`FEE_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return (sum > `FEE_MAX) ? fee_t'(`FEE_MAX) : sum[`FEE_W-1:0];
	endfunction

	assign slot_valid = (floor_t'(slot_spot >> 1) != '0);
	assign slot_idx   = slot_spot - spot_t'(2);

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			occupancy <= '0;
		else if (slot_valid && (slot_write || slot_clear))
			occupancy[slot_idx] <= slot_write ? slot_plate : '0;
	end

	// Meter reads rate times the edges after the one that stored the plate
	always_ff @(posedge clock) begin
		for (int i = 0; i < SPOTS; i++) begin
			if (slot_valid && slot_write && slot_idx == spot_t'(i))
				fee[i] <= '0;
			else if (occupancy[i] != '0)
				fee[i] <= add_sat(fee[i], class_rate(occupancy[i]));
		end
	end

	assign picked_fee = slot_valid ? fee[slot_idx] : '0;

	// Handicapped left spots of floors 1 and 2 count for neither type
	always_comb begin
		free_suv_count   = '0;
		free_sedan_count = '0;
		for (int i = 0; i < SPOTS; i++) begin
			if (occupancy[i] == '0 && !(i < 4 && i % 2 == 0)) begin
				if ((i / 2) % 2 == 0)
					free_suv_count = free_suv_count + 4'd1;   // Odd floor
				else
					free_sedan_count = free_sedan_count + 4'd1;
			end
		end
	end

endmodule

// ==== design/spot_allocator.sv ====
// Spot allocator
// Picks the best free spot for a plate and finds where a plate is parked
`include "parking_defines.svh"

module spot_allocator (
	input  parking_pkg::plate_t     plate,
	input  parking_pkg::occupancy_t occupancy,
	output parking_pkg::spot_t      free_spot,
	output parking_pkg::spot_t      found_spot,
	output logic                    free_found,
	output logic                    plate_found
);
	import parking_pkg::*;

	localparam int SPOTS = 2 * `FLOOR_COUNT;

	logic             handicap;
	logic             suv;          // Odd plate
	logic [SPOTS-1:0] reserved;     // Left spots of floors 1 and 2
	logic [SPOTS-1:0] odd_floor;
	logic [SPOTS-1:0] open_spot;    // Empty and usable by this plate
	logic [SPOTS-1:0] own_floor;
	logic             sedan_overflow;
	logic [SPOTS-1:0] candidates;

	assign handicap = (plate[`PLATE_W-1 -: 4] == 4'(`CLASS_HANDICAP));
	assign suv      = plate[0];

	// Index i is floor i/2+1, left side on even i
	always_comb begin
		for (int i = 0; i < SPOTS; i++) begin
			reserved[i]  = (i < 4) && (i % 2 == 0);
			odd_floor[i] = ((i / 2) % 2) == 0;
			open_spot[i] = (occupancy[i] == '0) && (handicap || !reserved[i]);
		end
	end

	assign own_floor = suv ? (open_spot & odd_floor) : (open_spot & ~odd_floor);

	// Sedans spill to odd floors only once no even-floor spot is left for them
	assign sedan_overflow = !suv && (own_floor == '0);
	assign candidates     = sedan_overflow ? (open_spot & odd_floor) : own_floor;

	// Scan top down so the lowest floor, left side, is the last to win
	always_comb begin
		free_found  = 1'b0;
		free_spot   = '0;
		plate_found = 1'b0;
		found_spot  = '0;
		for (int i = SPOTS - 1; i >= 0; i--) begin
			if (candidates[i]) begin
				free_found = 1'b1;
				free_spot  = spot_t'(i + 2);
			end
			if (plate != '0 && occupancy[i] == plate) begin
				plate_found = 1'b1;
				found_spot  = spot_t'(i + 2);
			end
		end
	end

endmodule

// ==== design/order_queue.sv ====
// Order queue
// Circular FIFO of park and retrieve orders waiting for the lift
`include "parking_defines.svh"

module order_queue (
	input  logic                clock,
	input  logic                reset,
	input  logic                in_mode,
	input  logic                out_mode,
	input  parking_pkg::plate_t license_plate,
	input  logic                pop,
	output parking_pkg::order_t head_order,
	output logic                queue_empty,
	output logic                queue_full
);
	import parking_pkg::*;

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

	order_t           entries [`QUEUE_DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic             push_ok;
	logic             pop_ok;
	order_t           new_order;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign queue_empty = (count == '0);
	assign queue_full  = (count == CNT_W'(`QUEUE_DEPTH));

	// Full is judged before the pop, so a pop never makes room for a push in the same cycle
	assign push_ok = (in_mode | out_mode) & ~queue_full;
	assign pop_ok  = pop & ~queue_empty;

	assign new_order.kind  = in_mode ? ORDER_PARK : ORDER_RETRIEVE; // Park wins a tie
	assign new_order.plate = license_plate;

	assign head_order = entries[head];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				tail <= next_ptr(tail);
			if (pop_ok)
				head <= next_ptr(head);
			count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
		end
	end

	always_ff @(posedge clock) begin
		if (push_ok)
			entries[tail] <= new_order;
	end

endmodule

// ==== design/parking_pkg.sv ====
// Parking tower types
// Plates, floors, spots, orders and lift events shared by all blocks
`include "parking_defines.svh"

package parking_pkg;

	typedef logic [`PLATE_W-1:0] plate_t; // Zero is an empty spot
	typedef logic [$clog2(`FLOOR_COUNT + 1)-1:0] floor_t;
	typedef logic [$bits(floor_t):0] spot_t; // Floor on top, bit 0 is the side (1 = right)
	typedef logic [`FEE_W-1:0] fee_t;

	// One plate per spot, spot 2 (floor 1 left) at index 0
	typedef plate_t [2*`FLOOR_COUNT-1:0] occupancy_t;

	typedef enum logic {
		ORDER_PARK,
		ORDER_RETRIEVE
	} order_kind_e;

	typedef struct packed {
		order_kind_e kind;
		plate_t      plate;
	} order_t;

	typedef enum logic [2:0] {
		EV_NONE,
		EV_PARKED,
		EV_PICKED,
		EV_DELIVERED,
		EV_REJECTED
	} event_kind_e;

	typedef struct packed {
		event_kind_e kind;
		plate_t      plate;
		spot_t       spot;
		fee_t        fee; // Only meaningful on EV_PICKED
	} lot_event_t;

	typedef enum logic [1:0] {
		LIFT_IDLE,
		LIFT_DECIDE,
		LIFT_ASCEND,
		LIFT_DESCEND
	} lift_state_e;

endpackage

// ==== design/parking_defines.svh ====
// Parking tower sizes, fee limits and plate class codes
// Class codes sit in the top nibble of a plate

`ifndef PARKING_DEFINES_SVH
`define PARKING_DEFINES_SVH

// License plate width, zero plate means no car
`define PLATE_W 16

// Parking floors above the ground floor, two spots each
`define FLOOR_COUNT 7

// Pending orders held before the lift serves them
`define QUEUE_DEPTH 8

// Fee meter width and its saturation value
`define FEE_W 8
`define FEE_MAX 255

// Top-nibble plate classes
`define CLASS_HANDICAP 9
`define CLASS_HYBRID 8

// Fee added per cycle, handicapped plates pay nothing
`define RATE_HYBRID 1
`define RATE_NORMAL 2

`endif
